/* include/sata_xport_consts.svh */
`ifndef SATA_XPORT_CONSTS_SVH
`define SATA_XPORT_CONSTS_SVH

// fifo geometry
`define XP_ADDR_W           9           // 512 entries
`define XP_DEPTH            512         // words per direction
`define XP_DATA_W           32          // dword payload
`define XP_MASK_W           2           // half-word mask
`define XP_TYPE_W           2           // word type code
`define XP_WORD_W           36          // type + mask + data

// fill thresholds, in words
`define XP_H2D_HEADROOM     8           // host stops below depth minus this
`define XP_XMIT_START_FILL  64          // start an incomplete fis at this fill
`define XP_D2H_MANY_FILL    8           // host may burst-read
`define XP_D2H_STOP_FILL    448         // link must pause

// type codes, both directions
`define XP_H2D_DATA         2'd0
`define XP_H2D_HEAD         2'd1
`define XP_H2D_LAST         2'd2
`define XP_D2H_DATA         2'd0
`define XP_D2H_HEAD         2'd1
`define XP_D2H_OK           2'd2
`define XP_D2H_ERR          2'd3

`endif

/* src/sata_xport_pkg.sv */
`default_nettype none

`include "sata_xport_consts.svh"

package sata_xport_pkg;

    typedef logic [`XP_DATA_W-1:0] dword_t;     // one fis dword
    typedef logic [`XP_MASK_W-1:0] mask_t;      // half-word enables, 2'b11 normally
    typedef logic [`XP_ADDR_W:0]   fill_t;      // 0..512, needs one extra bit
    typedef logic [`XP_WORD_W-1:0] fifo_word_t; // raw storage word

    typedef enum logic [`XP_TYPE_W-1:0] {
        H2D_DATA = `XP_H2D_DATA,                // fis body
        H2D_HEAD = `XP_H2D_HEAD,                // first dword of a fis
        H2D_LAST = `XP_H2D_LAST                 // final dword, closes the frame
    } h2d_type_e;

    typedef enum logic [`XP_TYPE_W-1:0] {
        D2H_DATA = `XP_D2H_DATA,                // fis body
        D2H_HEAD = `XP_D2H_HEAD,                // first received dword
        D2H_OK   = `XP_D2H_OK,                  // status word, fis good
        D2H_ERR  = `XP_D2H_ERR                  // status word, fis invalidated
    } d2h_type_e;

    typedef struct packed {
        h2d_type_e typ;                         // msbs of the fifo word
        mask_t     mask;
        dword_t    data;
    } h2d_word_t;

    typedef struct packed {
        d2h_type_e typ;
        mask_t     mask;
        dword_t    data;
    } d2h_word_t;

    typedef struct packed {
        mask_t  mask;                           // as delivered by the link
        dword_t data;
    } rx_word_t;

endpackage

`default_nettype wire

/* src/xport_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sata_xport_consts.svh"

module xport_fifo (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       wr,     // push wdata
    input  wire sata_xport_pkg::fifo_word_t wdata,
    input  wire logic                       rd,     // pop the head word
    output sata_xport_pkg::fifo_word_t      rdata,  // registered head word
    output logic                            nempty, // rdata holds a word
    output sata_xport_pkg::fill_t           fill    // words incl. output reg
);

    sata_xport_pkg::fifo_word_t mem [`XP_DEPTH];    // words behind the output reg
    logic [`XP_ADDR_W-1:0]      wptr;
    logic [`XP_ADDR_W-1:0]      rptr;
    logic                       push;               // accepted write
    logic                       pop;                // accepted read
    logic                       load;               // output reg takes a new word
    logic                       mem_has;            // array not empty
    logic                       bypass;             // write goes straight to rdata

    assign push    = wr && (fill < sata_xport_pkg::fill_t'(`XP_DEPTH)); // full drops word
    assign pop     = rd && nempty;
    assign load    = !nempty || pop;                // empty slot or head leaving
    assign mem_has = fill > sata_xport_pkg::fill_t'(nempty);
    assign bypass  = load && !mem_has && push;      // nothing older queued

    // array write side
    always_ff @(posedge clk) begin
        if (push && !bypass) begin
            mem[wptr] <= wdata;
        end
    end

    // head register payload
    always_ff @(posedge clk) begin
        if (load) begin
            if (mem_has) begin
                rdata <= mem[rptr];                 // oldest queued word
            end else if (push) begin
                rdata <= wdata;                     // straight from an empty fifo
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wptr   <= '0;
            rptr   <= '0;
            nempty <= 1'b0;
            fill   <= '0;
        end else begin
            if (push && !bypass) begin
                wptr <= wptr + 1'b1;                // wraps at 512
            end
            if (load && mem_has) begin
                rptr <= rptr + 1'b1;
            end
            if (load) begin
                nempty <= mem_has || push;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;              // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/h2d_frame_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sata_xport_consts.svh"

module h2d_frame_ctrl (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      wr,        // word accepted into h2d fifo
    input  wire sata_xport_pkg::h2d_type_e wr_type,   // type of that word
    input  wire sata_xport_pkg::fill_t     fill,      // h2d fifo fill
    input  wire logic                      frame_ack, // link took the request
    output logic                           frame_req  // ask link for a new frame
);

    logic pending;      // head written, frame not yet requested
    logic head_wr;
    logic last_wr;
    logic fill_ok;      // enough buffered to start early
    logic start;

    assign head_wr = wr && (wr_type == sata_xport_pkg::H2D_HEAD);
    assign last_wr = wr && (wr_type == sata_xport_pkg::H2D_LAST);
    assign fill_ok = fill >= sata_xport_pkg::fill_t'(`XP_XMIT_START_FILL);

    // whole fis buffered, or enough of it that the link won't starve
    assign start = pending && (last_wr || fill_ok);

    always_ff @(posedge clk) begin
        if (rst || frame_req) begin
            pending <= 1'b0;                // one request per fis
        end else if (head_wr) begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_req <= 1'b0;
        end else if (start) begin
            frame_req <= 1'b1;
        end else if (frame_ack) begin
            frame_req <= 1'b0;              // drop after handshake
        end
    end

endmodule

`default_nettype wire

/* src/d2h_fis_tagger.sv */
`timescale 1ns/1ps
`default_nettype none

module d2h_fis_tagger (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 rx_valid,         // link delivers a dword
    input  wire logic                 incom_start,      // new incoming fis
    input  wire logic                 incom_done,       // fis ended, crc good
    input  wire logic                 incom_invalidate, // fis ended with errors
    output logic                      push,             // write d2h fifo
    output sata_xport_pkg::d2h_type_e push_type         // type for that write
);

    sata_xport_pkg::d2h_type_e type_r;  // type of the next word to push
    logic                      fis_end; // done or invalidate this cycle
    logic                      fis_over; // status word goes out now

    assign fis_end = incom_done || incom_invalidate;

    // head after start, body after any word, status after the end
    always_ff @(posedge clk) begin
        if (rst || incom_start) begin
            type_r <= sata_xport_pkg::D2H_HEAD;
        end else if (rx_valid) begin
            type_r <= sata_xport_pkg::D2H_DATA;
        end else if (fis_end) begin
            type_r <= incom_invalidate ? sata_xport_pkg::D2H_ERR
                                       : sata_xport_pkg::D2H_OK;
        end
    end

    // only once per fis, and only if some body was received
    always_ff @(posedge clk) begin
        if (rst) begin
            fis_over <= 1'b0;
        end else begin
            fis_over <= fis_end && (type_r == sata_xport_pkg::D2H_DATA);
        end
    end

    assign push      = rx_valid || fis_over;
    assign push_type = type_r;          // already ok/err when fis_over fires

endmodule

`default_nettype wire

/* src/sata_xport_buffers.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sata_xport_consts.svh"

module sata_xport_buffers (
    input  wire logic                      clk,
    input  wire logic                      rst,
    // host write side
    input  wire sata_xport_pkg::h2d_word_t h2d_in,
    input  wire logic                      h2d_valid,
    output logic                           h2d_ready,    // room left in h2d fifo
    // link transmit side
    output sata_xport_pkg::h2d_word_t      tx_word,
    output logic                           tx_last,      // tx_word closes the fis
    output logic                           tx_valid,
    input  wire logic                      tx_strobe,    // link consumes tx_word
    output logic                           frame_req,
    input  wire logic                      frame_ack,
    // link receive side
    input  wire sata_xport_pkg::rx_word_t  rx_word,
    input  wire logic                      rx_valid,
    input  wire logic                      incom_start,
    input  wire logic                      incom_done,
    input  wire logic                      incom_invalidate,
    output logic                           link_busy,    // link must hold off
    // host read side
    output sata_xport_pkg::d2h_word_t      d2h_out,
    output logic                           d2h_valid,
    output logic                           d2h_many,     // burst worth available
    input  wire logic                      d2h_ready
);

    logic                       h2d_wr;
    logic                       h2d_rd;
    sata_xport_pkg::fifo_word_t h2d_rdata;
    sata_xport_pkg::fill_t      h2d_fill;
    logic                       d2h_wr;
    logic                       d2h_rd;
    sata_xport_pkg::d2h_type_e  d2h_type_in;    // from the tagger
    sata_xport_pkg::d2h_word_t  d2h_win;        // assembled fifo input
    sata_xport_pkg::fifo_word_t d2h_rdata;
    sata_xport_pkg::fill_t      d2h_fill;

    // host to device
    assign h2d_ready = h2d_fill < sata_xport_pkg::fill_t'(`XP_DEPTH - `XP_H2D_HEADROOM);
    assign h2d_wr    = h2d_valid && h2d_ready;
    assign h2d_rd    = tx_valid && tx_strobe;
    assign tx_word   = sata_xport_pkg::h2d_word_t'(h2d_rdata);
    assign tx_last   = tx_word.typ == sata_xport_pkg::H2D_LAST;

    xport_fifo u_h2d_fifo (
        .clk    (clk),
        .rst    (rst),
        .wr     (h2d_wr),
        .wdata  (h2d_in),           // struct packs straight into storage
        .rd     (h2d_rd),
        .rdata  (h2d_rdata),
        .nempty (tx_valid),
        .fill   (h2d_fill)
    );

    h2d_frame_ctrl u_h2d_frame_ctrl (
        .clk       (clk),
        .rst       (rst),
        .wr        (h2d_wr),
        .wr_type   (h2d_in.typ),
        .fill      (h2d_fill),
        .frame_ack (frame_ack),
        .frame_req (frame_req)
    );

    // device to host
    d2h_fis_tagger u_d2h_fis_tagger (
        .clk              (clk),
        .rst              (rst),
        .rx_valid         (rx_valid),
        .incom_start      (incom_start),
        .incom_done       (incom_done),
        .incom_invalidate (incom_invalidate),
        .push             (d2h_wr),
        .push_type        (d2h_type_in)
    );

    assign d2h_win.typ  = d2h_type_in;
    assign d2h_win.mask = rx_word.mask;     // status word carries don't-care data
    assign d2h_win.data = rx_word.data;
    assign d2h_rd       = d2h_valid && d2h_ready;

    xport_fifo u_d2h_fifo (
        .clk    (clk),
        .rst    (rst),
        .wr     (d2h_wr),
        .wdata  (d2h_win),
        .rd     (d2h_rd),
        .rdata  (d2h_rdata),
        .nempty (d2h_valid),
        .fill   (d2h_fill)
    );

    assign d2h_out   = sata_xport_pkg::d2h_word_t'(d2h_rdata);
    assign d2h_many  = d2h_fill >= sata_xport_pkg::fill_t'(`XP_D2H_MANY_FILL);
    assign link_busy = d2h_fill >= sata_xport_pkg::fill_t'(`XP_D2H_STOP_FILL); // leaves 64 spare

endmodule

`default_nettype wire

/* dv/tb_sata_xport.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sata_xport_consts.svh"

module tb_sata_xport;

    localparam int N_H2D_FIS     = 16;              // random h2d frames
    localparam int LONG_FIS      = 600;             // fills the h2d fifo
    localparam int N_RX_FIS      = 24;              // d2h frames, host reading
    localparam int N_BIG_FIS     = 12;              // d2h frames, host stalled
    localparam int PLANNED_WORDS = N_H2D_FIS * 100 + LONG_FIS + N_RX_FIS * 31 + N_BIG_FIS * 81;
    localparam int TIMEOUT_CYCLES = PLANNED_WORDS * 40 + 5000;
    localparam int H2D_LIMIT     = `XP_DEPTH - `XP_H2D_HEADROOM;

    logic                      clk;
    logic                      rst;
    sata_xport_pkg::h2d_word_t h2d_in;
    logic                      h2d_valid;
    logic                      h2d_ready;
    sata_xport_pkg::h2d_word_t tx_word;
    logic                      tx_last;
    logic                      tx_valid;
    logic                      tx_strobe;
    logic                      frame_req;
    logic                      frame_ack;
    sata_xport_pkg::rx_word_t  rx_word;
    logic                      rx_valid;
    logic                      incom_start;
    logic                      incom_done;
    logic                      incom_invalidate;
    logic                      link_busy;
    sata_xport_pkg::d2h_word_t d2h_out;
    logic                      d2h_valid;
    logic                      d2h_many;
    logic                      d2h_ready;

    logic                      strobe_en;           // link may pop tx words
    logic                      rd_en;               // host may pop d2h words
    int                        errors;
    int                        h2d_seen;
    int                        d2h_seen;

    // reference model state
    sata_xport_pkg::h2d_word_t h2d_exp_q[$];
    sata_xport_pkg::d2h_word_t d2h_exp_q[$];
    int                        h2d_count;           // words buffered h2d
    int                        d2h_count;           // words buffered d2h
    logic                      fr_m;                // predicted frame_req
    logic                      pend_m;              // predicted pending fis
    logic                      rx_first;            // next rx word is the head
    logic                      rx_got;              // body seen since start
    logic                      status_due;          // status word lands next edge
    sata_xport_pkg::d2h_type_e status_typ;

    sata_xport_buffers u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                      // 125 MHz
    end

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // one host frame of head, body and last words with random valid gaps
    task automatic send_fis(input int len);
        sata_xport_pkg::h2d_word_t w;
        for (int i = 0; i < len; i++) begin
            if (i == 0) begin
                w.typ = sata_xport_pkg::H2D_HEAD;
            end else if (i == len - 1) begin
                w.typ = sata_xport_pkg::H2D_LAST;
            end else begin
                w.typ = sata_xport_pkg::H2D_DATA;
            end
            w.mask = sata_xport_pkg::mask_t'($urandom_range(0, 3));
            w.data = $urandom;
            while ($urandom_range(0, 3) == 0) begin
                h2d_valid <= 1'b0;                  // idle cycle
                @(posedge clk);
            end
            h2d_in    <= w;
            h2d_valid <= 1'b1;
            do @(posedge clk); while (!h2d_ready); // held until accepted
        end
        h2d_valid <= 1'b0;
    endtask

    // request raised and answered before the next head goes in
    task automatic wait_frame_idle();
        do @(posedge clk); while (frame_req);
    endtask

    // one received fis from the link that pauses while link_busy
    task automatic send_rx_fis(input int len, input logic bad);
        sata_xport_pkg::rx_word_t r;
        incom_start <= 1'b1;
        @(posedge clk);
        incom_start <= 1'b0;
        for (int i = 0; i < len; i++) begin
            while (link_busy || $urandom_range(0, 3) == 0) begin
                rx_valid <= 1'b0;
                @(posedge clk);
            end
            r.mask = sata_xport_pkg::mask_t'($urandom_range(0, 3));
            r.data = $urandom;
            rx_word  <= r;
            rx_valid <= 1'b1;
            @(posedge clk);
        end
        rx_valid <= 1'b0;
        @(posedge clk);                             // end pulse apart from data
        if (bad) begin
            incom_invalidate <= 1'b1;
        end else begin
            incom_done <= 1'b1;
        end
        @(posedge clk);
        incom_done       <= 1'b0;
        incom_invalidate <= 1'b0;
        repeat (2) @(posedge clk);                  // status slot stays free of data
    endtask

    // link and host side random pacing
    always @(posedge clk) begin
        tx_strobe <= strobe_en && ($urandom_range(0, 1) == 1);
        d2h_ready <= rd_en && ($urandom_range(0, 2) != 0);
    end

    // link answers frame requests after a short random delay
    initial begin
        forever begin
            @(posedge clk);
            if (frame_req && !rst) begin
                repeat ($urandom_range(1, 6)) @(posedge clk);
                frame_ack <= 1'b1;
                do @(posedge clk); while (frame_req);
                frame_ack <= 1'b0;
            end
        end
    end

    // scoreboard works on the pre-edge values that the dut samples
    always @(posedge clk) begin : scoreboard
        logic                      h2d_acc;
        logic                      h2d_pop;
        logic                      d2h_pop;
        logic                      start;
        sata_xport_pkg::h2d_word_t exp_tx;
        sata_xport_pkg::d2h_word_t exp_rx;
        if (rst) begin
            h2d_exp_q.delete();
            d2h_exp_q.delete();
            h2d_count  = 0;
            d2h_count  = 0;
            fr_m       = 1'b0;
            pend_m     = 1'b0;
            rx_first   = 1'b0;
            rx_got     = 1'b0;
            status_due = 1'b0;
        end else begin
            check(h2d_ready, h2d_count < H2D_LIMIT, "h2d_ready vs buffered words");
            check(tx_valid, h2d_count != 0, "tx_valid vs buffered words");
            check(frame_req, fr_m, "frame_req");
            check(d2h_valid, d2h_count != 0, "d2h_valid vs buffered words");
            check(d2h_many, d2h_count >= `XP_D2H_MANY_FILL, "d2h_many");
            check(link_busy, d2h_count >= `XP_D2H_STOP_FILL, "link_busy");
            check(d2h_count <= `XP_DEPTH, 1, "d2h words beyond fifo depth");
            h2d_acc = h2d_valid && (h2d_count < H2D_LIMIT);
            h2d_pop = tx_valid && tx_strobe;
            d2h_pop = d2h_valid && d2h_ready;
            // h2d stream
            if (h2d_pop) begin
                check(h2d_exp_q.size() != 0, 1, "tx word with nothing expected");
                if (h2d_exp_q.size() != 0) begin
                    exp_tx = h2d_exp_q.pop_front();
                    check(tx_word, exp_tx, "tx_word");
                    check(tx_last, exp_tx.typ == sata_xport_pkg::H2D_LAST, "tx_last");
                    h2d_seen++;
                end
            end
            if (h2d_acc) begin
                h2d_exp_q.push_back(h2d_in);
            end
            // frame request rule uses the old pend_m and fr_m on the right
            start  = pend_m && ((h2d_acc && h2d_in.typ == sata_xport_pkg::H2D_LAST)
                                || h2d_count >= `XP_XMIT_START_FILL);
            pend_m = fr_m ? 1'b0 : (h2d_acc && h2d_in.typ == sata_xport_pkg::H2D_HEAD) ? 1'b1
                                                                                      : pend_m;
            fr_m   = start ? 1'b1 : frame_ack ? 1'b0 : fr_m;
            h2d_count = h2d_count + int'(h2d_acc) - int'(h2d_pop);
            // d2h stream
            if (d2h_pop) begin
                check(d2h_exp_q.size() != 0, 1, "d2h word with nothing expected");
                if (d2h_exp_q.size() != 0) begin
                    exp_rx = d2h_exp_q.pop_front();
                    check(d2h_out.typ, exp_rx.typ, "d2h word type");
                    if (exp_rx.typ == sata_xport_pkg::D2H_HEAD ||
                        exp_rx.typ == sata_xport_pkg::D2H_DATA) begin
                        check({d2h_out.mask, d2h_out.data}, {exp_rx.mask, exp_rx.data},
                              "d2h word payload");
                    end
                    d2h_seen++;
                end
            end
            d2h_count = d2h_count + int'(status_due) + int'(rx_valid) - int'(d2h_pop);
            if (status_due) begin
                exp_rx.typ  = status_typ;           // payload is don't-care
                exp_rx.mask = '0;
                exp_rx.data = '0;
                d2h_exp_q.push_back(exp_rx);
                status_due = 1'b0;
            end
            if (rx_valid) begin
                exp_rx.typ  = rx_first ? sata_xport_pkg::D2H_HEAD : sata_xport_pkg::D2H_DATA;
                exp_rx.mask = rx_word.mask;
                exp_rx.data = rx_word.data;
                d2h_exp_q.push_back(exp_rx);
                rx_first = 1'b0;
                rx_got   = 1'b1;
            end
            if (incom_start) begin
                rx_first = 1'b1;
                rx_got   = 1'b0;
            end
            if (incom_done || incom_invalidate) begin
                status_due = rx_got;                // only when a body came in
                status_typ = incom_invalidate ? sata_xport_pkg::D2H_ERR : sata_xport_pkg::D2H_OK;
                rx_got     = 1'b0;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h64ca_7bb7));
        errors           = 0;
        h2d_seen         = 0;
        d2h_seen         = 0;
        rst              = 1'b1;
        h2d_in           = '0;
        h2d_valid        = 1'b0;
        tx_strobe        = 1'b0;
        frame_ack        = 1'b0;
        rx_word          = '0;
        rx_valid         = 1'b0;
        incom_start      = 1'b0;
        incom_done       = 1'b0;
        incom_invalidate = 1'b0;
        d2h_ready        = 1'b0;
        strobe_en        = 1'b0;
        rd_en            = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        // h2d frames mostly short and some past the start fill
        strobe_en <= 1'b1;
        for (int n = 0; n < N_H2D_FIS; n++) begin
            send_fis(($urandom_range(0, 3) == 0) ? $urandom_range(65, 100)
                                                 : $urandom_range(2, 40));
            wait_frame_idle();
        end
        while (tx_valid) @(posedge clk);            // start the long frame from empty
        strobe_en <= 1'b0;
        @(posedge clk);
        fork
            send_fis(LONG_FIS);
            begin
                wait (!h2d_ready);                  // fifo at the headroom mark
                repeat (16) @(posedge clk);
                strobe_en <= 1'b1;
            end
        join
        wait_frame_idle();
        // d2h frames with the host reading
        rd_en <= 1'b1;
        for (int n = 0; n < N_RX_FIS; n++) begin
            send_rx_fis($urandom_range(1, 30), $urandom_range(0, 3) == 0);
        end
        // host stalled until the link has been throttled
        rd_en <= 1'b0;
        fork
            for (int n = 0; n < N_BIG_FIS; n++) begin
                send_rx_fis($urandom_range(40, 80), $urandom_range(0, 3) == 0);
            end
            begin
                wait (link_busy);
                repeat (40) @(posedge clk);
                rd_en <= 1'b1;
            end
        join
        repeat (4) @(posedge clk);
        while (tx_valid || d2h_valid) @(posedge clk);
        repeat (4) @(posedge clk);
        check(h2d_exp_q.size(), 0, "h2d words never transmitted");
        check(d2h_exp_q.size(), 0, "d2h words never delivered");
        $display("errors: %0d, h2d words checked: %0d, d2h words checked: %0d",
                 errors, h2d_seen, d2h_seen);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
src/sata_xport_pkg.sv
src/xport_fifo.sv
src/h2d_frame_ctrl.sv
src/d2h_fis_tagger.sv
src/sata_xport_buffers.sv
dv/tb_sata_xport.sv

/* Bender.yml */
package:
  name: sata_xport_buffers

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/sata_xport_pkg.sv
      - src/xport_fifo.sv
      - src/h2d_frame_ctrl.sv
      - src/d2h_fis_tagger.sv
      - src/sata_xport_buffers.sv

  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_sata_xport.sv
